//--- rtl/serv_pkg.sv
// Shared definitions for the bit-serial execution unit
// Word width, ALU operation encoding, the request bundle seen at the
// handshake and the stage strobes that sequence the serial datapath

package serv_pkg;

   // Operand and result width
   localparam int XLEN = 32;

   // Operations handled by the serial ALU
   typedef enum logic [2:0] {
      ALU_ADD  = 3'd0,
      ALU_SUB  = 3'd1,
      ALU_AND  = 3'd2,
      ALU_OR   = 3'd3,
      ALU_XOR  = 3'd4,
      ALU_SLT  = 3'd5,
      ALU_SLTU = 3'd6
   } alu_op_e;

   // One request, held stable by the requester while i_req is high
   typedef struct packed {
      alu_op_e         op;
      logic [XLEN-1:0] rs1;
      logic [XLEN-1:0] rs2;
   } exec_req_t;

   // Strobes from the control FSM to the datapath
   typedef struct packed {
      // Capture a new request
      logic load;
      // A serial chunk is in flight
      logic cnt_en;
      // First chunk of the word
      logic cnt0;
      // Finalize cycle after the last chunk
      logic done;
   } exec_stage_t;

endpackage

//--- rtl/serv_state.sv
// Control FSM of the bit-serial execution unit
// Accepts one request over a four-phase req/ack handshake, then steps
// the datapath through a load cycle, XLEN/W serial chunks and a done
// cycle before raising the acknowledge
`timescale 1ns/10ps

module serv_state
  #(parameter int W = 1)
   (
   input  logic                  i_clk,
   input  logic                  i_rst_n,
   input  logic                  i_req,
   output logic                  o_ack,
   output serv_pkg::exec_stage_t o_stage);

   import serv_pkg::*;

   localparam int CYCLES = XLEN / W;
   localparam int CW     = $clog2(CYCLES);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_RUN,
      ST_DONE,
      ST_ACK
   } state_e;

   state_e        state;
   logic [CW-1:0] cnt;
   logic          last;

   assign last = (cnt == CW'(CYCLES - 1));

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         state <= ST_IDLE;
         cnt   <= '0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (i_req) begin
                  state <= ST_RUN;
                  cnt   <= '0;
               end
            end
            ST_RUN: begin
               cnt <= cnt + 1'b1;
               if (last) begin
                  state <= ST_DONE;
               end
            end
            ST_DONE: begin
               state <= ST_ACK;
            end
            // Hold the ack until the requester lets go
            ST_ACK: begin
               if (!i_req) begin
                  state <= ST_IDLE;
               end
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   assign o_ack = (state == ST_ACK);

   always_comb begin
      o_stage        = '0;
      o_stage.load   = (state == ST_IDLE) && i_req;
      o_stage.cnt_en = (state == ST_RUN);
      o_stage.cnt0   = (state == ST_RUN) && (cnt == '0);
      o_stage.done   = (state == ST_DONE);
   end

endmodule

//--- rtl/serv_opbuf.sv
// Operand buffer for the serial datapath
// Loads both operands and the operation in parallel, then shifts the
// operands right by W bits per chunk, LSB chunk first
`timescale 1ns/10ps

module serv_opbuf
  #(parameter int W = 1)
   (
   input  logic                  i_clk,
   //State
   input  serv_pkg::exec_stage_t i_stage,
   //Data
   input  serv_pkg::exec_req_t   i_req_data,
   output serv_pkg::alu_op_e     o_op,
   output logic [W-1:0]          o_rs1,
   output logic [W-1:0]          o_rs2);

   import serv_pkg::*;

   logic [XLEN-1:0] rs1_q;
   logic [XLEN-1:0] rs2_q;

   always_ff @(posedge i_clk) begin
      if (i_stage.load) begin
         o_op  <= i_req_data.op;
         rs1_q <= i_req_data.rs1;
         rs2_q <= i_req_data.rs2;
      end else if (i_stage.cnt_en) begin
         // Zeros come in at the top
         rs1_q <= {{W{1'b0}}, rs1_q[XLEN-1:W]};
         rs2_q <= {{W{1'b0}}, rs2_q[XLEN-1:W]};
      end
   end

   // Current chunk
   assign o_rs1 = rs1_q[W-1:0];
   assign o_rs2 = rs2_q[W-1:0];

endmodule

//--- rtl/serv_alu.sv
// Serial ALU
// Adds or subtracts one W-bit chunk per cycle with the carry kept
// between chunks, does the bitwise operations directly, and resolves
// signed and unsigned set-less-than from the top chunk
`timescale 1ns/10ps

module serv_alu
  #(parameter int W = 1)
   (
   input  logic                  i_clk,
   //State
   input  serv_pkg::exec_stage_t i_stage,
   //Control
   input  serv_pkg::alu_op_e     i_op,
   //Data
   input  logic [W-1:0]          i_rs1,
   input  logic [W-1:0]          i_rs2,
   output logic [W-1:0]          o_rd,
   output logic                  o_set_lsb);

   import serv_pkg::*;

   logic         cmp_op;
   logic         sub;
   logic [W-1:0] op_b;
   logic         carry_in;
   logic         carry_q;
   logic [W:0]   sum;
   logic         slt_bit;
   logic         cmp_bit;
   logic         cmp_q;

   assign cmp_op = (i_op == ALU_SLT) || (i_op == ALU_SLTU);
   assign sub    = (i_op == ALU_SUB) || cmp_op;

   // Two's complement subtract: invert rs2, carry in one on the first chunk
   assign op_b     = sub ? ~i_rs2 : i_rs2;
   assign carry_in = i_stage.cnt0 ? sub : carry_q;
   assign sum      = {1'b0, i_rs1} + {1'b0, op_b} + {{W{1'b0}}, carry_in};

   // Only meaningful on the top chunk
   assign slt_bit = (i_rs1[W-1] != i_rs2[W-1]) ? i_rs1[W-1] : sum[W-1];
   assign cmp_bit = (i_op == ALU_SLTU) ? ~sum[W] : slt_bit;

   // Last chunk written wins, so cmp_q holds the top chunk result
   always_ff @(posedge i_clk) begin
      if (i_stage.cnt_en) begin
         carry_q <= sum[W];
         cmp_q   <= cmp_bit;
      end
   end

   always_comb begin
      case (i_op)
         ALU_ADD,
         ALU_SUB:  o_rd = sum[W-1:0];
         ALU_AND:  o_rd = i_rs1 & i_rs2;
         ALU_OR:   o_rd = i_rs1 | i_rs2;
         ALU_XOR:  o_rd = i_rs1 ^ i_rs2;
         default:  o_rd = '0;
      endcase
   end

   assign o_set_lsb = i_stage.done && cmp_op && cmp_q;

endmodule

//--- rtl/serv_rdbuf.sv
// Result buffer
// Collects W-bit result chunks from the top down so the finished word
// lands in order, then merges the compare bit into bit 0
`timescale 1ns/10ps

module serv_rdbuf
  #(parameter int W = 1)
   (
   input  logic                      i_clk,
   //State
   input  serv_pkg::exec_stage_t     i_stage,
   //Data
   input  logic [W-1:0]              i_rd,
   input  logic                      i_set_lsb,
   output logic [serv_pkg::XLEN-1:0] o_rd);

   import serv_pkg::*;

   logic [XLEN-1:0] rd_q;

   always_ff @(posedge i_clk) begin
      if (i_stage.load) begin
         rd_q <= '0;
      end else if (i_stage.cnt_en) begin
         rd_q <= {i_rd, rd_q[XLEN-1:W]};
      end else if (i_stage.done) begin
         // Compare result, zero extended
         rd_q[0] <= rd_q[0] | i_set_lsb;
      end
   end

   assign o_rd = rd_q;

endmodule

//--- rtl/serv_exec_top.sv
// Bit-serial integer execution unit
// Takes an operation and two operands over a four-phase handshake,
// processes W bits per clock and returns the 32-bit result with o_ack
`timescale 1ns/10ps

module serv_exec_top
  #(parameter int W = 1)
   (
   input  logic                      i_clk,
   input  logic                      i_rst_n,
   //Request
   input  logic                      i_req,
   input  serv_pkg::exec_req_t       i_req_data,
   //Response
   output logic                      o_ack,
   output logic [serv_pkg::XLEN-1:0] o_rd);

   import serv_pkg::*;

   exec_stage_t  stage;
   alu_op_e      op;
   logic [W-1:0] rs1;
   logic [W-1:0] rs2;
   logic [W-1:0] alu_rd;
   logic         set_lsb;

   serv_state #(.W(W)) state
     (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_req   (i_req),
      .o_ack   (o_ack),
      .o_stage (stage));

   serv_opbuf #(.W(W)) opbuf
     (
      .i_clk      (i_clk),
      .i_stage    (stage),
      .i_req_data (i_req_data),
      .o_op       (op),
      .o_rs1      (rs1),
      .o_rs2      (rs2));

   serv_alu #(.W(W)) alu
     (
      .i_clk     (i_clk),
      .i_stage   (stage),
      .i_op      (op),
      .i_rs1     (rs1),
      .i_rs2     (rs2),
      .o_rd      (alu_rd),
      .o_set_lsb (set_lsb));

   serv_rdbuf #(.W(W)) rdbuf
     (
      .i_clk     (i_clk),
      .i_stage   (stage),
      .i_rd      (alu_rd),
      .i_set_lsb (set_lsb),
      .o_rd      (o_rd));

endmodule

//--- verification/serv_exec_clkgen.sv
// Clock and reset generator for the execution unit testbench
// Free-running clock, reset held low for a fixed number of cycles
`timescale 1ns/10ps

module serv_exec_clkgen
  #(parameter int PERIOD_NS  = 10,
    parameter int RST_CYCLES = 8)
   (
   output logic o_clk,
   output logic o_rst_n);

   initial begin
      o_clk   = 1'b0;
      o_rst_n = 1'b0;
      forever #(PERIOD_NS / 2) o_clk = ~o_clk;
   end

   // Release on a falling edge, away from the sampling edge
   initial begin
      repeat (RST_CYCLES) @(posedge o_clk);
      @(negedge o_clk);
      o_rst_n = 1'b1;
   end

endmodule

//--- verification/serv_exec_checker.sv
// Handshake checker for the bit-serial execution unit
// Bound to the top level, watches the four-phase req/ack protocol
`timescale 1ns/10ps

module serv_exec_checker
   (
   input logic i_clk,
   input logic i_rst_n,
   input logic i_req,
   input logic i_ack);

   int unsigned n_fail = 0;

   // Reset leaves the acknowledge low
   ack_reset_a: assert property (@(posedge i_clk) !i_rst_n |=> !i_ack)
      else begin
         $error("o_ack is high after a reset cycle");
         n_fail++;
      end

   ack_rise_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                                $rose(i_ack) |-> $past(i_req))
      else begin
         $error("o_ack rose while i_req was low");
         n_fail++;
      end

   // Back-pressure keeps the acknowledge up
   ack_hold_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                                i_ack && i_req |=> i_ack)
      else begin
         $error("o_ack fell while i_req was still high");
         n_fail++;
      end

endmodule

//--- verification/serv_exec_tb.sv
// Testbench for the bit-serial execution unit
// Directed tests for idle behavior, add/sub, bitwise ops, compares and
// back-pressure, checked against a word-level reference model
`timescale 1ns/10ps

module serv_exec_tb;

   import serv_pkg::*;

   localparam int          W          = 1;
   localparam int          CLK_NS     = 10;
   localparam int          RST_CYCLES = 8;
   localparam int          CYCLES     = XLEN / W;
   // Load cycle, serial chunks and done cycle
   localparam int          LATENCY    = CYCLES + 2;
   localparam int          ACK_LIMIT  = CYCLES + 10;
   localparam int          N_TESTS    = 5;
   localparam int          N_REQS     = 40;
   localparam longint      WDOG_NS    = longint'(N_TESTS) * N_REQS * (CYCLES + 10) * CLK_NS
                                        + RST_CYCLES * CLK_NS;
   localparam int unsigned SEED       = 32'hb424_7c30;

   logic            clk;
   logic            rst_n;
   logic            i_req;
   exec_req_t       i_req_data;
   logic            o_ack;
   logic [XLEN-1:0] o_rd;

   string cur_test;
   int    test_errs;
   int    tests_passed;
   int    tests_failed;

   serv_exec_clkgen #(.PERIOD_NS(CLK_NS), .RST_CYCLES(RST_CYCLES)) clkgen_i
     (
      .o_clk   (clk),
      .o_rst_n (rst_n));

   serv_exec_top #(.W(W)) dut_i
     (
      .i_clk      (clk),
      .i_rst_n    (rst_n),
      .i_req      (i_req),
      .i_req_data (i_req_data),
      .o_ack      (o_ack),
      .o_rd       (o_rd));

   bind serv_exec_top serv_exec_checker hs_check_i
     (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_req   (i_req),
      .i_ack   (o_ack));

   function automatic logic [XLEN-1:0] ref_result(input alu_op_e op,
                                                  input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
      case (op)
         ALU_ADD:  return a + b;
         ALU_SUB:  return a - b;
         ALU_AND:  return a & b;
         ALU_OR:   return a | b;
         ALU_XOR:  return a ^ b;
         ALU_SLT:  return {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
         ALU_SLTU: return {{(XLEN-1){1'b0}}, a < b};
         default:  return '0;
      endcase
   endfunction

   task automatic start_test(input string name);
      cur_test  = name;
      test_errs = 0;
   endtask

   task automatic finish_test();
      if (test_errs == 0) begin
         tests_passed++;
         $display("[%s] passed", cur_test);
      end else begin
         tests_failed++;
         $display("[%s] failed with %0d errors", cur_test, test_errs);
      end
   endtask

   // One full handshake, holding i_req for extra cycles after the ack
   task automatic run_req(input alu_op_e op, input logic [XLEN-1:0] a,
                          input logic [XLEN-1:0] b, input int hold,
                          output logic [XLEN-1:0] res);
      logic [XLEN-1:0] exp;
      int              cycles;
      exp            = ref_result(op, a, b);
      i_req_data.op  = op;
      i_req_data.rs1 = a;
      i_req_data.rs2 = b;
      i_req          = 1'b1;
      cycles         = 0;
      while (!o_ack && cycles < ACK_LIMIT) begin
         @(negedge clk);
         cycles++;
      end
      res = o_rd;
      if (!o_ack) begin
         $display("No acknowledge from the DUT within %0d cycles in %s", ACK_LIMIT, cur_test);
         test_errs++;
         i_req = 1'b0;
         return;
      end
      assert (cycles == LATENCY)
         else begin
            $display("Mismatch in %s latency: expected %0d, actual %0d",
                     cur_test, LATENCY, cycles);
            test_errs++;
         end
      assert (o_rd === exp)
         else begin
            $display("Mismatch in %s %s %h,%h: expected %h, actual %h",
                     cur_test, op.name(), a, b, exp, o_rd);
            test_errs++;
         end
      repeat (hold) begin
         @(negedge clk);
         assert (o_ack)
            else begin
               $display("In %s o_ack dropped while i_req was still high", cur_test);
               test_errs++;
            end
         assert (o_rd === exp)
            else begin
               $display("Mismatch in %s held result: expected %h, actual %h",
                        cur_test, exp, o_rd);
               test_errs++;
            end
      end
      i_req = 1'b0;
      @(negedge clk);
      assert (!o_ack)
         else begin
            $display("In %s o_ack did not fall one cycle after i_req fell", cur_test);
            test_errs++;
         end
   endtask

   task automatic idle_no_ack();
      start_test("idle");
      repeat (20) begin
         @(negedge clk);
         assert (!o_ack)
            else begin
               $display("In %s o_ack is high with no request", cur_test);
               test_errs++;
            end
      end
      finish_test();
   endtask

   task automatic add_sub_wrap();
      logic [XLEN-1:0] edge_vals [3];
      logic [XLEN-1:0] res;
      logic [XLEN-1:0] a;
      logic [XLEN-1:0] b;
      start_test("add_sub");
      edge_vals = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000};
      foreach (edge_vals[i]) begin
         foreach (edge_vals[j]) begin
            run_req(ALU_ADD, edge_vals[i], edge_vals[j], 0, res);
            run_req(ALU_SUB, edge_vals[i], edge_vals[j], 0, res);
         end
      end
      repeat (6) begin
         a = $urandom();
         b = $urandom();
         run_req(ALU_ADD, a, b, 0, res);
         run_req(ALU_SUB, a, b, 0, res);
      end
      finish_test();
   endtask

   task automatic bitwise_ops();
      logic [XLEN-1:0] res;
      logic [XLEN-1:0] a;
      logic [XLEN-1:0] b;
      start_test("logic");
      repeat (8) begin
         a = $urandom();
         b = $urandom();
         run_req(ALU_AND, a, b, 0, res);
         run_req(ALU_OR, a, b, 0, res);
         run_req(ALU_XOR, a, b, 0, res);
      end
      finish_test();
   endtask

   task automatic set_less_than();
      logic [XLEN-1:0] a_vals [$];
      logic [XLEN-1:0] b_vals [$];
      logic [XLEN-1:0] r_slt;
      logic [XLEN-1:0] r_sltu;
      start_test("compare");
      // Equal signs, opposite signs, equal values, then random pairs
      a_vals = '{32'd5, 32'd9, 32'hffff_fff0, 32'h8000_0000,
                 32'd1, 32'hffff_ffff, 32'h0000_1234, 32'h8000_0000};
      b_vals = '{32'd9, 32'd5, 32'hffff_ffff, 32'd1,
                 32'h8000_0000, 32'd0, 32'h0000_1234, 32'h8000_0000};
      repeat (4) begin
         a_vals.push_back($urandom());
         b_vals.push_back($urandom());
      end
      foreach (a_vals[i]) begin
         run_req(ALU_SLT, a_vals[i], b_vals[i], 0, r_slt);
         run_req(ALU_SLTU, a_vals[i], b_vals[i], 0, r_sltu);
         if (a_vals[i][XLEN-1] != b_vals[i][XLEN-1]) begin
            assert (r_slt != r_sltu)
               else begin
                  $display("In %s signed and unsigned compare agree on %h,%h",
                           cur_test, a_vals[i], b_vals[i]);
                  test_errs++;
               end
         end
      end
      finish_test();
   endtask

   task automatic backpressure_hold();
      logic [XLEN-1:0] res;
      start_test("backpressure");
      repeat (4) begin
         run_req(alu_op_e'($urandom_range(6, 0)), $urandom(), $urandom(),
                 $urandom_range(20, 1), res);
      end
      // Follow-up request without extra hold
      run_req(ALU_ADD, $urandom(), $urandom(), 0, res);
      finish_test();
   endtask

   initial begin
      #(WDOG_NS);
      $display("Timeout: the run did not finish within %0d ns", WDOG_NS);
      $display("TB FAILED");
      $finish;
   end

   initial begin
      int unsigned chk_fails;
      i_req        = 1'b0;
      i_req_data   = '0;
      tests_passed = 0;
      tests_failed = 0;
      void'($urandom(SEED));
      @(posedge rst_n);
      @(negedge clk);
      idle_no_ack();
      add_sub_wrap();
      bitwise_ops();
      set_less_than();
      backpressure_hold();
      chk_fails = dut_i.hs_check_i.n_fail;
      $display("Summary: %0d tests passed, %0d tests failed, %0d handshake assertion failures",
               tests_passed, tests_failed, chk_fails);
      if (tests_failed == 0 && chk_fails == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

//--- files.f
rtl/serv_pkg.sv
rtl/serv_state.sv
rtl/serv_opbuf.sv
rtl/serv_alu.sv
rtl/serv_rdbuf.sv
rtl/serv_exec_top.sv
verification/serv_exec_clkgen.sv
verification/serv_exec_checker.sv
verification/serv_exec_tb.sv
